// File: circular_dma.f
dma_axi_pkg.sv
dma_ctrl_pkg.sv
axis_fifo.sv
circular_dma_fsm.sv
circular_dma.sv
tb_axi_mem.sv
tb_circular_dma.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the circular DMA testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -Wno-fatal \
	--top-module tb_circular_dma -f circular_dma.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "result: fail"
	exit 1
fi

echo "result: pass"
exit 0

// File: tb_circular_dma.sv
// Testbench for the circular stream-to-memory DMA.
// LFSR stream data into the DUT, memory model on AXI, checks by assertions.

`timescale 1ns/1ns

module tb_circular_dma;
	import dma_axi_pkg::*;
	import dma_ctrl_pkg::*;

	localparam int MAX_BURST   = 16;
	localparam int FIFO_DEPTH  = 64;
	localparam int BURST_BYTES = MAX_BURST * BEAT_BYTES;
	localparam int TMO         = 2000;
	localparam int W_IRQ       = 0;
	localparam int W_RESP      = 1;
	localparam int W_ADDR      = 2;

	logic        clk = 1'b0;
	logic        rst_n;
	axis_beat_t  s_axis_beat;
	logic        s_axis_valid;
	logic        s_axis_ready;
	dma_cfg_t    cfg;
	logic [2:0]  clear_irq;
	dma_status_t status;
	axi_aw_t     aw;
	logic        awvalid;
	logic        awready;
	axi_w_t      w;
	logic        wvalid;
	logic        wready;
	axi_b_t      b;
	logic        bvalid;
	logic        bready;
	logic [1:0]  resp_code;
	logic [2:0]  stall = '0;
	logic [2:0]  irq_en_q;
	logic [31:0] data_lfsr  = 32'hc875_4ec5;
	logic [31:0] stall_lfsr = 32'hc875_4ec5;
	logic [63:0] sent [$];   // scoreboard of accepted beats.
	axi_aw_t     aw_log [$];
	int          b_count = 0;
	int          errors = 0;
	int          tests = 0;
	int          failed = 0;

	always #4 clk = ~clk;

	circular_dma #(.MAX_BURST(MAX_BURST), .FIFO_DEPTH(FIFO_DEPTH)) dut (
		.clk(clk), .rst_n(rst_n),
		.s_axis_beat(s_axis_beat), .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready),
		.cfg(cfg), .clear_irq(clear_irq), .status(status),
		.m_axi_aw(aw), .m_axi_awvalid(awvalid), .m_axi_awready(awready),
		.m_axi_w(w), .m_axi_wvalid(wvalid), .m_axi_wready(wready),
		.m_axi_b(b), .m_axi_bvalid(bvalid), .m_axi_bready(bready)
	);

	tb_axi_mem u_mem (
		.clk(clk), .rst_n(rst_n),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.resp_code(resp_code), .stall(stall)
	);

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	always @(posedge clk) begin : stall_gen
		logic [5:0] r;
		for (int i = 0; i < 6; i++) begin
			stall_lfsr = lfsr_step(stall_lfsr);
			r[i] = stall_lfsr[0];
		end
		stall <= {r[5] & r[4], r[3] & r[2], r[1] & r[0]}; // about one cycle in four.
	end

	// ==================================================
	// protocol and interrupt checks
	// ==================================================
	assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(aw))
	else begin
		$display("AW channel changed while waiting for awready");
		errors++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(w))
	else begin
		$display("W channel changed while waiting for wready");
		errors++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) bready && !bvalid |=> bready)
	else begin
		$display("bready dropped before bvalid arrived");
		errors++;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (awvalid && awready) begin
				aw_log.push_back(aw);
			end
			if (bvalid && bready) begin
				b_count++;
			end
			assert ((status.irq & ~irq_en_q) == 3'd0) else begin
				$display("interrupt raised while its enable bit was low, irq 0x%0h", status.irq);
				errors++;
			end
			assert (!(awvalid && status.irq[IRQ_ERROR])) else begin
				$display("new burst address issued after an error response");
				errors++;
			end
		end
		irq_en_q <= cfg.enable_irq;
	end

	// ==================================================
	// helpers
	// ==================================================
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	function automatic logic event_seen(input int kind, input int target);
		case (kind)
			W_IRQ:   return status.irq[target];
			W_RESP:  return b_count >= target;
			default: return aw_log.size() >= target;
		endcase
	endfunction

	// returns on a falling edge.
	task automatic wait_until(input int kind, input int target, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!event_seen(kind, target) && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!event_seen(kind, target)) begin
			report_failure({"timed out waiting for ", what});
		end
	endtask

	task automatic next_word(output logic [63:0] d);
		for (int i = 0; i < 64; i++) begin
			data_lfsr = lfsr_step(data_lfsr);
			d[i] = data_lfsr[0];
		end
	endtask

	task automatic send_beats(input int count, input int last_idx);
		logic [63:0] d;
		int n;
		@(posedge clk);
		for (int i = 0; i < count; i++) begin
			next_word(d);
			s_axis_beat  <= '{data: d, last: (i == last_idx)};
			s_axis_valid <= 1'b1;
			n = 0;
			@(negedge clk);
			while (!s_axis_ready && n < TMO) begin
				@(negedge clk);
				n++;
			end
			if (!s_axis_ready) begin
				report_failure("stream source timed out waiting for s_axis_ready");
			end
			@(posedge clk); // beat taken here.
			sent.push_back(d);
		end
		s_axis_valid <= 1'b0;
	endtask

	task automatic stop_and_clear();
		@(posedge clk);
		cfg.enable <= 1'b0;
		clear_irq  <= 3'b111;
		@(posedge clk);
		clear_irq  <= 3'b000;
	endtask

	task automatic check_bursts(input int count, input int len, input logic [31:0] base);
		check_value("aw count", aw_log.size(), count);
		for (int i = 0; i < aw_log.size(); i++) begin
			check_value($sformatf("aw[%0d].len", i), aw_log[i].len, len);
			check_value($sformatf("aw[%0d].addr", i), aw_log[i].addr,
				base + 32'(i * BURST_BYTES));
		end
	endtask

	task automatic check_memory(input logic [31:0] base);
		int idx;
		for (int i = 0; i < sent.size(); i++) begin
			idx = int'(base >> 3) + i;
			check_value($sformatf("mem[%0d]", idx), u_mem.mem[idx], sent[i]);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: fail, %0d errors", tests, name, errors - err_before);
		end
	endtask

	task automatic run_error(input logic [1:0] code, input logic [2:0] flag);
		@(posedge clk);
		sent.delete();
		aw_log.delete();
		resp_code <= code;
		send_beats(2 * MAX_BURST, -1); // a second burst stays queued.
		cfg.enable <= 1'b1;
		wait_until(W_IRQ, IRQ_ERROR, "IRQ_ERROR");
		repeat (30) @(negedge clk);
		check_value("aw count", aw_log.size(), 1);
		check_value("status_flags", status.status_flags, flag);
		check_value("irq", status.irq, 3'b100);
		stop_and_clear();

		// drain the queued beats with a good flushed run.
		@(posedge clk);
		resp_code  <= 2'b00;
		cfg.flush  <= 1'b1;
		cfg.enable <= 1'b1;
		wait_until(W_IRQ, IRQ_DONE, "IRQ_DONE after drain");
		stop_and_clear();
		cfg.flush <= 1'b0;
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int e;
		int b0;
		int n_aw;
		rst_n        <= 1'b0;
		s_axis_beat  <= '0;
		s_axis_valid <= 1'b0;
		cfg          <= '0;
		clear_irq    <= 3'b000;
		resp_code    <= 2'b00;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		e = errors;
		check_value("awvalid", awvalid, 0);
		check_value("wvalid", wvalid, 0);
		check_value("bready", bready, 0);
		check_value("irq", status.irq, 0);
		check_value("fifo_empty", status.fifo_empty, 0);
		check_value("status_flags", status.status_flags, ST_OK);
		check_value("s_axis_ready", s_axis_ready, 1);
		end_test("reset state", e);

		e = errors;
		@(posedge clk);
		cfg.enable_irq <= 3'b111;
		cfg.mem_base   <= 32'h0000_0400;
		cfg.mem_size   <= 32'(4 * BURST_BYTES);
		cfg.timeout    <= '1;
		send_beats(64, 50);
		cfg.enable <= 1'b1;
		wait_until(W_IRQ, IRQ_DONE, "IRQ_DONE");
		check_bursts(4, MAX_BURST - 1, 32'h0000_0400);
		check_value("bytes_written", status.bytes_written, 512);
		check_value("last_msg_end", status.last_msg_end, 408); // tlast on beat 50.
		check_value("irq", status.irq, 3'b001);
		check_memory(32'h0000_0400);
		stop_and_clear();
		end_test("full window", e);

		e = errors;
		@(posedge clk);
		sent.delete();
		aw_log.delete();
		cfg.mem_base <= 32'h0;
		cfg.flush    <= 1'b1;
		send_beats(5, 4);
		cfg.enable <= 1'b1;
		wait_until(W_IRQ, IRQ_DONE, "IRQ_DONE");
		check_bursts(1, 4, 32'h0);
		check_value("bytes_written", status.bytes_written, 40);
		check_value("last_msg_end", status.last_msg_end, 40);
		check_memory(32'h0);
		stop_and_clear();
		cfg.flush <= 1'b0;
		end_test("flush", e);

		e = errors;
		run_error(2'b10, ST_SLVERR);
		run_error(2'b11, ST_DECERR);
		end_test("error response", e);

		// short timeout and a long gap before the second burst.
		e = errors;
		@(posedge clk);
		resp_code    <= 2'b00;
		cfg.mem_size <= 32'(3 * BURST_BYTES);
		cfg.timeout  <= 32'd60;
		b0 = b_count;
		send_beats(MAX_BURST, -1);
		cfg.enable <= 1'b1;
		wait_until(W_RESP, b0 + 1, "first response");
		repeat (150) @(negedge clk);
		check_value("irq timeout", status.irq[IRQ_TIMEOUT], 0);
		send_beats(MAX_BURST, -1);
		wait_until(W_RESP, b0 + 2, "second response");
		check_value("irq timeout", status.irq[IRQ_TIMEOUT], 1);
		send_beats(MAX_BURST, -1);
		wait_until(W_IRQ, IRQ_DONE, "IRQ_DONE");
		check_value("bytes_written", status.bytes_written, 384);
		stop_and_clear();
		end_test("timeout", e);

		e = errors;
		@(posedge clk);
		cfg.enable_irq <= 3'b110;
		cfg.flush      <= 1'b1;
		cfg.mem_size   <= 32'(BURST_BYTES);
		cfg.timeout    <= '1;
		b0 = b_count;
		send_beats(3, 2);
		cfg.enable <= 1'b1;
		wait_until(W_RESP, b0 + 1, "masked run response");
		repeat (4) @(negedge clk);
		check_value("irq", status.irq, 0);
		@(posedge clk);
		cfg.enable     <= 1'b0;
		cfg.flush      <= 1'b0;
		cfg.enable_irq <= 3'b111;
		resp_code      <= 2'b10;
		send_beats(MAX_BURST, -1);
		cfg.enable <= 1'b1;
		wait_until(W_IRQ, IRQ_ERROR, "IRQ_ERROR");
		@(posedge clk);
		resp_code <= 2'b00;
		n_aw = aw_log.size();
		send_beats(MAX_BURST, -1);
		repeat (20) @(negedge clk);
		check_value("aw count", aw_log.size(), n_aw);
		@(posedge clk);
		clear_irq <= 3'b100;
		@(posedge clk);
		clear_irq <= 3'b000;
		@(negedge clk);
		check_value("irq", status.irq, 0);
		wait_until(W_ADDR, n_aw + 1, "burst after clear");
		wait_until(W_IRQ, IRQ_DONE, "IRQ_DONE");
		stop_and_clear();
		end_test("irq mask and clear", e);

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: tb_axi_mem.sv
// AXI4 write slave model for the DMA testbench.
// Word memory, settable response code, ready stalls driven from outside.

`timescale 1ns/1ns

module tb_axi_mem #(
	parameter int WORDS = 256
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  dma_axi_pkg::axi_aw_t  aw,
	input  logic                  awvalid,
	output logic                  awready,
	input  dma_axi_pkg::axi_w_t   w,
	input  logic                  wvalid,
	output logic                  wready,
	output dma_axi_pkg::axi_b_t   b,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [1:0]            resp_code,
	input  logic [2:0]            stall      // aw, w and b, one bit each.
);
	import dma_axi_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	logic [AXI_DATA_W-1:0] mem [WORDS];
	logic                  busy;  // burst accepted, not yet answered.
	logic                  b_due;
	logic [IDX_W-1:0]      idx;

	assign awready = !busy && !stall[0];
	assign wready  = busy && !b_due && !stall[1];
	assign b.resp  = resp_code;

	always_ff @(posedge clk) begin
		if (wvalid && wready) begin
			mem[idx] <= w.data;
		end
	end

	// ==================================================
	// burst tracking
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			b_due  <= 1'b0;
			bvalid <= 1'b0;
			idx    <= '0;
		end else begin
			if (awvalid && awready) begin
				busy <= 1'b1;
				idx  <= aw.addr[IDX_W+2:3]; // byte address to word index.
			end
			if (wvalid && wready) begin
				idx <= idx + IDX_W'(1);
				if (w.last) begin
					b_due <= 1'b1;
				end
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				b_due  <= 1'b0;
				busy   <= 1'b0;
			end else if (b_due && !bvalid && !stall[2]) begin
				bvalid <= 1'b1;
			end
		end
	end

endmodule

// File: circular_dma.sv
// Circular stream-to-memory DMA, top level.
// Stream FIFO in front of the burst FSM that writes the memory window over AXI4.

`timescale 1ns/1ns

module circular_dma #(
	parameter int MAX_BURST  = 16,
	parameter int FIFO_DEPTH = 64  // power of two, at least MAX_BURST.
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dma_axi_pkg::axis_beat_t    s_axis_beat,
	input  logic                       s_axis_valid,
	output logic                       s_axis_ready,
	input  dma_ctrl_pkg::dma_cfg_t     cfg,
	input  logic [2:0]                 clear_irq,
	output dma_ctrl_pkg::dma_status_t  status,
	output dma_axi_pkg::axi_aw_t       m_axi_aw,
	output logic                       m_axi_awvalid,
	input  logic                       m_axi_awready,
	output dma_axi_pkg::axi_w_t        m_axi_w,
	output logic                       m_axi_wvalid,
	input  logic                       m_axi_wready,
	input  dma_axi_pkg::axi_b_t        m_axi_b,
	input  logic                       m_axi_bvalid,
	output logic                       m_axi_bready
);
	import dma_axi_pkg::*;

	axis_beat_t                 head;
	logic                       pop;
	logic [$clog2(FIFO_DEPTH):0] occupancy;

	axis_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_beat   (s_axis_beat),
		.in_valid  (s_axis_valid),
		.in_ready  (s_axis_ready),
		.pop       (pop),
		.head      (head),
		.occupancy (occupancy)
	);

	circular_dma_fsm #(
		.MAX_BURST  (MAX_BURST),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.clear_irq (clear_irq),
		.head      (head),
		.occupancy (occupancy),
		.pop       (pop),
		.status    (status),
		.aw        (m_axi_aw),
		.awvalid   (m_axi_awvalid),
		.awready   (m_axi_awready),
		.w         (m_axi_w),
		.wvalid    (m_axi_wvalid),
		.wready    (m_axi_wready),
		.b         (m_axi_b),
		.bvalid    (m_axi_bvalid),
		.bready    (m_axi_bready)
	);

endmodule

// File: circular_dma_fsm.sv
// Burst scheduler and AXI write master of the circular DMA.
// Sizes bursts from FIFO occupancy, tracks the window and raises interrupts.

`timescale 1ns/1ns

module circular_dma_fsm #(
	parameter int MAX_BURST  = 16,
	parameter int FIFO_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  dma_ctrl_pkg::dma_cfg_t       cfg,
	input  logic [2:0]                   clear_irq,
	input  dma_axi_pkg::axis_beat_t      head,
	input  logic [$clog2(FIFO_DEPTH):0]  occupancy,
	output logic                         pop,
	output dma_ctrl_pkg::dma_status_t    status,
	output dma_axi_pkg::axi_aw_t         aw,
	output logic                         awvalid,
	input  logic                         awready,
	output dma_axi_pkg::axi_w_t          w,
	output logic                         wvalid,
	input  logic                         wready,
	input  dma_axi_pkg::axi_b_t          b,
	input  logic                         bvalid,
	output logic                         bready
);
	import dma_axi_pkg::*;
	import dma_ctrl_pkg::*;

	localparam int OCC_W       = $clog2(FIFO_DEPTH) + 1;
	localparam int BURST_BYTES = MAX_BURST * BEAT_BYTES;

	typedef enum logic [1:0] {
		S_WAIT_ENABLE,
		S_WRITE_ADDR,
		S_DATA_BURST,
		S_WAIT_RESP
	} state_t;

	state_t      state;
	logic [2:0]  irq;
	logic [2:0]  status_flags;
	logic [31:0] bytes_written;
	logic [31:0] last_msg_end;
	logic [31:0] last_msg_end_b; // offset noted during the running burst.
	logic [31:0] mem_size_q;     // bytes_written value of the final burst.
	logic [31:0] timeout_cnt;
	logic        fifo_empty;
	logic [7:0]  beat_cnt;

	logic        head_valid;
	logic        full_ok;
	logic        run_start;
	logic        burst_go;
	logic [7:0]  next_len;
	logic        aw_fire;
	logic        w_fire;
	logic        b_fire;
	logic        b_ok;
	logic        tmo_clr;

	assign head_valid = (occupancy != '0);
	assign full_ok    = (occupancy >= OCC_W'(MAX_BURST));

	assign run_start = (state == S_WAIT_ENABLE) && cfg.enable && (irq == 3'd0)
		&& (cfg.mem_size >= BURST_BYTES) && !fifo_empty;

	// short burst only on flush with something queued.
	assign burst_go = (state == S_WRITE_ADDR) && !awvalid
		&& (full_ok || (cfg.flush && head_valid));
	assign next_len = full_ok ? 8'(MAX_BURST - 1) : 8'(occupancy) - 8'd1;

	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;
	assign b_fire  = bready & bvalid;
	assign b_ok    = ~b.resp[1]; // OKAY or EXOKAY.

	// ==================================================
	// W channel, streamed straight from the FIFO head
	// ==================================================
	always_comb begin
		w.data = head.data;
		w.last = (state == S_DATA_BURST) && (beat_cnt == aw.len);
		wvalid = (state == S_DATA_BURST) && head_valid;
	end

	assign pop = w_fire;

	// ==================================================
	// control state
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= S_WAIT_ENABLE;
			irq           <= '0;
			status_flags  <= ST_OK;
			bytes_written <= '0;
			last_msg_end  <= '0;
			fifo_empty    <= 1'b0;
			beat_cnt      <= '0;
			awvalid       <= 1'b0;
			bready        <= 1'b0;
		end else begin
			irq <= irq & ~clear_irq & cfg.enable_irq; // masked sticky bits.

			case (state)
				S_WAIT_ENABLE: begin
					fifo_empty <= !head_valid;
					if (run_start) begin
						state         <= S_WRITE_ADDR;
						bytes_written <= '0;
						last_msg_end  <= '0;
						status_flags  <= ST_OK;
						beat_cnt      <= '0;
					end
				end

				S_WRITE_ADDR: begin
					if (burst_go) begin
						awvalid <= 1'b1;
					end else if (aw_fire) begin
						awvalid <= 1'b0;
						state   <= S_DATA_BURST;
					end
				end

				S_DATA_BURST: begin
					if (w_fire) begin
						beat_cnt <= beat_cnt + 8'd1;
						if (w.last) begin
							beat_cnt <= '0;
							bready   <= 1'b1;
							state    <= S_WAIT_RESP;
						end
					end
				end

				S_WAIT_RESP: begin
					if (b_fire) begin
						bready     <= 1'b0;
						fifo_empty <= !head_valid;
						if (b_ok) begin
							last_msg_end  <= last_msg_end_b;
							bytes_written <= bytes_written
								+ ({24'd0, aw.len} + 32'd1) * BEAT_BYTES;
							if ((bytes_written == mem_size_q) || (cfg.flush && !head_valid)) begin
								state          <= S_WAIT_ENABLE;
								irq[IRQ_DONE]  <= cfg.enable_irq[IRQ_DONE];
							end else begin
								state <= S_WRITE_ADDR;
								if (timeout_cnt >= cfg.timeout) begin
									irq[IRQ_TIMEOUT] <= cfg.enable_irq[IRQ_TIMEOUT];
								end
							end
						end else begin
							state           <= S_WAIT_ENABLE;
							irq[IRQ_ERROR]  <= cfg.enable_irq[IRQ_ERROR];
							status_flags    <= b.resp[0] ? ST_DECERR : ST_SLVERR;
						end
					end
				end

				default: state <= S_WAIT_ENABLE;
			endcase
		end
	end

	// ==================================================
	// address, length and window payload
	// ==================================================
	always_ff @(posedge clk) begin
		if (run_start) begin
			aw.addr        <= cfg.mem_base;
			mem_size_q     <= cfg.mem_size - BURST_BYTES;
			last_msg_end_b <= '0;
		end
		if (burst_go) begin
			aw.len <= next_len;
		end
		if (aw_fire) begin
			aw.addr <= aw.addr + AXI_ADDR_W'(BURST_BYTES); // full step, even when short.
		end
		if (w_fire && head.last) begin
			last_msg_end_b <= bytes_written + ({24'd0, beat_cnt} + 32'd1) * BEAT_BYTES;
		end
	end

	// saturating cycle counter.
	assign tmo_clr = run_start | (b_fire & b_ok) | irq[IRQ_TIMEOUT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timeout_cnt <= '0;
		end else if (tmo_clr) begin
			timeout_cnt <= '0;
		end else if (!(&timeout_cnt)) begin
			timeout_cnt <= timeout_cnt + 32'd1;
		end
	end

	always_comb begin
		status.irq           = irq;
		status.status_flags  = status_flags;
		status.bytes_written = bytes_written;
		status.last_msg_end  = last_msg_end;
		status.fifo_empty    = fifo_empty;
	end

endmodule

// File: axis_fifo.sv
// Stream FIFO for the circular DMA.
// Keeps data and tlast together, shows the head beat with no read latency.

`timescale 1ns/1ns

module axis_fifo #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  dma_axi_pkg::axis_beat_t      in_beat,
	input  logic                         in_valid,
	output logic                         in_ready,
	input  logic                         pop,
	output dma_axi_pkg::axis_beat_t      head,
	output logic [$clog2(FIFO_DEPTH):0]  occupancy
);
	import dma_axi_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int OCC_W = PTR_W + 1;

	axis_beat_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             push;
	logic             do_pop;

	assign in_ready = (occupancy != OCC_W'(FIFO_DEPTH)); // low only when full.
	assign push     = in_valid & in_ready;
	assign do_pop   = pop & (occupancy != '0);

	assign head = mem[rd_ptr]; // head is live while occupancy is nonzero.

	// ==================================================
	// storage
	// ==================================================
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_beat;
		end
	end

	// ==================================================
	// pointers and occupancy
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// push and pop together leave the count alone.
			case ({push, do_pop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

endmodule

// File: dma_ctrl_pkg.sv
// Control types for the circular DMA.
// Configuration levels, reported status, interrupt bits and status codes.

package dma_ctrl_pkg;

	// configuration, held as levels.
	typedef struct packed {
		logic        enable;
		logic [2:0]  enable_irq;
		logic [31:0] mem_base;
		logic [31:0] mem_size;   // window size in bytes.
		logic [31:0] timeout;    // cycles.
		logic        flush;
	} dma_cfg_t;

	typedef struct packed {
		logic [2:0]  irq;
		logic [2:0]  status_flags;
		logic [31:0] bytes_written;
		logic [31:0] last_msg_end;
		logic        fifo_empty;
	} dma_status_t;

	// ==================================================
	// interrupt bit indices
	// ==================================================
	parameter int IRQ_DONE    = 0;
	parameter int IRQ_TIMEOUT = 1;
	parameter int IRQ_ERROR   = 2;

	// ==================================================
	// status flag codes
	// ==================================================
	parameter logic [2:0] ST_OK     = 3'b001;
	parameter logic [2:0] ST_SLVERR = 3'b010;
	parameter logic [2:0] ST_DECERR = 3'b100;

endpackage

// File: dma_axi_pkg.sv
// AXI bus types for the circular DMA.
// Carries the stream beat and the write address, data and response channels.

package dma_axi_pkg;

	// ==================================================
	// bus widths
	// ==================================================
	parameter int AXI_ADDR_W = 32;
	parameter int AXI_DATA_W = 64;
	parameter int BEAT_BYTES = AXI_DATA_W / 8; // 8 bytes per beat.

	// ==================================================
	// channel payloads
	// ==================================================

	// one AXI-Stream beat.
	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic                  last;
	} axis_beat_t;

	// write address channel.
	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [7:0]            len; // beats minus one.
	} axi_aw_t;

	// write data channel.
	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic                  last;
	} axi_w_t;

	// write response channel.
	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

endpackage
